// ==== src/dcfifo_defines.svh ====
`ifndef DCFIFO_DEFINES_SVH
`define DCFIFO_DEFINES_SVH

// --------------------
// FIFO geometry
// --------------------

// Number of memory words, power of two
`define DCFIFO_DEPTH 16

// Memory address width, log2 of the depth
`define DCFIFO_ADDR_W 4

// Payload data width, flags travel on top of this
`define DCFIFO_DATA_W 8

// Flops per pointer crossing
`define DCFIFO_SYNC_STAGES 2

// --------------------
// Status port
// --------------------

// Status bus width
`define DCFIFO_CSR_W 32

// Level and threshold field in the low bits of a word
`define DCFIFO_FIELD_W 24

// Word addresses
`define DCFIFO_ADDR_LEVEL 1'b0
`define DCFIFO_ADDR_THRESH 1'b1

`endif

// ==== src/dcfifo_pkg.sv ====
`default_nettype none

`include "dcfifo_defines.svh"

package dcfifo_pkg;

    // Extra top bit tells a wrapped pointer from an equal one
    localparam int PTR_W = `DCFIFO_ADDR_W + 1;

    typedef logic [PTR_W-1:0] ptr_t;

    // --------------------
    // Gray conversion
    // --------------------

    // Adjacent values differ in one bit
    function automatic ptr_t bin_to_gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Running XOR from the top bit down
    function automatic ptr_t gray_to_bin(input ptr_t gray);
        ptr_t bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

// ==== src/gray_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_defines.svh"

module gray_sync #(
    parameter int WIDTH  = `DCFIFO_ADDR_W + 1,
    parameter int STAGES = `DCFIFO_SYNC_STAGES
) (
    input  logic             in_clk,
    input  logic             in_reset_n,
    input  logic [WIDTH-1:0] gray_in,
    output logic [WIDTH-1:0] gray_out
);

    // Hardening chain, stage 0 samples the foreign domain
    logic [WIDTH-1:0] sync_q [STAGES];

    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            sync_q <= '{default: '0};
        end else begin
            sync_q[0] <= gray_in;
            // Shift toward the last stage
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Last stage is stable in this domain
    assign gray_out = sync_q[STAGES-1];

endmodule

`default_nettype wire

// ==== src/payload_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_defines.svh"

module payload_ram (
    input  logic                      wr_clk,
    input  logic                      wr_en,
    input  logic [`DCFIFO_ADDR_W-1:0] wr_addr,
    input  logic [`DCFIFO_DATA_W+1:0] wr_data,
    input  logic                      rd_clk,
    input  logic [`DCFIFO_ADDR_W-1:0] rd_addr,
    output logic [`DCFIFO_DATA_W+1:0] rd_data
);

    // Word layout is {sop, eop, data}
    logic [`DCFIFO_DATA_W+1:0] mem [`DCFIFO_DEPTH];

    // Write port on the producer clock
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port on the consumer clock
    // Registered every edge, the address is the next read pointer
    always_ff @(posedge rd_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== src/fifo_write_side.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_defines.svh"

module fifo_write_side
    import dcfifo_pkg::*;
(
    input  logic                      in_clk,
    input  logic                      in_reset_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  ptr_t                      rd_ptr_gray_sync,
    output logic                      wr_en,
    output logic [`DCFIFO_ADDR_W-1:0] wr_addr,
    output ptr_t                      wr_ptr_gray,
    output ptr_t                      in_fill_level
);

    ptr_t wr_ptr;
    ptr_t wr_ptr_next;
    ptr_t rd_ptr_bin;
    logic full;
    logic accept;

    // --------------------
    // Handshake
    // --------------------

    assign in_ready = ~full;
    assign accept   = in_valid & in_ready;

    // Memory write on every accepted beat
    assign wr_en   = accept;
    assign wr_addr = wr_ptr[`DCFIFO_ADDR_W-1:0];

    // --------------------
    // Pointers
    // --------------------

    assign wr_ptr_next = accept ? wr_ptr + ptr_t'(1) : wr_ptr;

    // Read pointer as seen from this domain
    assign rd_ptr_bin = gray_to_bin(rd_ptr_gray_sync);

    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_ptr        <= '0;
            wr_ptr_gray   <= '0;
            full          <= 1'b0;
            in_fill_level <= '0;
        end else begin
            wr_ptr <= wr_ptr_next;
            // Gray register launches the crossing, one bit moves per beat
            wr_ptr_gray <= bin_to_gray(wr_ptr);
            // Full when the address bits match but the wrap bits differ
            full <= (wr_ptr_next[`DCFIFO_ADDR_W-1:0] == rd_ptr_bin[`DCFIFO_ADDR_W-1:0])
                 && (wr_ptr_next[`DCFIFO_ADDR_W] != rd_ptr_bin[`DCFIFO_ADDR_W]);
            // memory words only, output stage not counted
            in_fill_level <= wr_ptr_next - rd_ptr_bin;
        end
    end

endmodule

`default_nettype wire

// ==== src/fifo_read_side.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_defines.svh"

module fifo_read_side
    import dcfifo_pkg::*;
(
    input  logic                      out_clk,
    input  logic                      out_reset_n,
    input  ptr_t                      wr_ptr_gray_sync,
    output logic [`DCFIFO_ADDR_W-1:0] rd_addr,
    output ptr_t                      rd_ptr_gray,
    input  logic [`DCFIFO_DATA_W+1:0] mem_data,
    input  logic                      out_ready,
    output logic                      out_valid,
    output logic [`DCFIFO_DATA_W-1:0] out_data,
    output logic                      out_startofpacket,
    output logic                      out_endofpacket,
    output ptr_t                      out_fill_level
);

    ptr_t rd_ptr;
    ptr_t rd_ptr_next;
    ptr_t wr_ptr_bin;
    ptr_t mem_count;
    logic empty;
    logic stage_load;
    logic pop;
    logic [`DCFIFO_DATA_W+1:0] out_payload;

    // --------------------
    // Pop control
    // --------------------

    // Stage takes a word when it is empty or being drained
    assign stage_load = out_ready | ~out_valid;
    assign pop        = stage_load & ~empty;

    assign rd_ptr_next = pop ? rd_ptr + ptr_t'(1) : rd_ptr;

    // Memory looks one pop ahead so its register holds the word at rd_ptr
    assign rd_addr = rd_ptr_next[`DCFIFO_ADDR_W-1:0];

    // Write pointer as seen from this domain
    assign wr_ptr_bin = gray_to_bin(wr_ptr_gray_sync);

    // --------------------
    // Pointers and flags
    // --------------------

    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            empty       <= 1'b1;
            mem_count   <= '0;
            out_valid   <= 1'b0;
        end else begin
            rd_ptr <= rd_ptr_next;
            // Launch point of the read pointer crossing
            rd_ptr_gray <= bin_to_gray(rd_ptr);
            // Equal pointers, wrap bit included
            empty     <= (rd_ptr_next == wr_ptr_bin);
            mem_count <= wr_ptr_bin - rd_ptr_next;
            if (stage_load) begin
                out_valid <= ~empty;
            end
        end
    end

    // --------------------
    // Output stage
    // --------------------

    // Payload follows the valid flag, no clear needed
    always_ff @(posedge out_clk) begin
        if (stage_load) begin
            out_payload <= mem_data;
        end
    end

    assign {out_startofpacket, out_endofpacket, out_data} = out_payload;

    // Includes the beat parked in the output stage
    assign out_fill_level = mem_count + ptr_t'(out_valid);

endmodule

`default_nettype wire

// ==== src/level_status.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_defines.svh"

module level_status
    import dcfifo_pkg::*;
#(
    parameter bit ALMOST_ABOVE = 1'b1
) (
    input  logic                     in_clk,
    input  logic                     in_reset_n,
    input  ptr_t                     fill_level,
    input  logic                     csr_address,
    input  logic                     csr_read,
    input  logic                     csr_write,
    input  logic [`DCFIFO_CSR_W-1:0] csr_writedata,
    output logic [`DCFIFO_CSR_W-1:0] csr_readdata,
    output logic                     almost
);

    logic [`DCFIFO_FIELD_W-1:0] level_q;
    logic [`DCFIFO_FIELD_W-1:0] thresh_q;

    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            level_q      <= '0;
            thresh_q     <= '0;
            almost       <= 1'b0;
            csr_readdata <= '0;
        end else begin
            level_q <= `DCFIFO_FIELD_W'(fill_level);
            if (csr_write && csr_address == `DCFIFO_ADDR_THRESH) begin
                thresh_q <= csr_writedata[`DCFIFO_FIELD_W-1:0];
            end
            // Write wins over a read in the same cycle
            if (csr_read && !csr_write) begin
                csr_readdata <= (csr_address == `DCFIFO_ADDR_LEVEL)
                              ? `DCFIFO_CSR_W'(level_q)
                              : `DCFIFO_CSR_W'(thresh_q);
            end
            almost <= ALMOST_ABOVE ? (level_q >= thresh_q) : (level_q <= thresh_q);
        end
    end

endmodule

`default_nettype wire

// ==== src/dcfifo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_defines.svh"

module dcfifo_top
    import dcfifo_pkg::*;
(
    input  logic                      in_clk,
    input  logic                      in_reset_n,
    input  logic                      out_clk,
    input  logic                      out_reset_n,

    // Write-side stream
    input  logic [`DCFIFO_DATA_W-1:0] in_data,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic                      in_startofpacket,
    input  logic                      in_endofpacket,

    // Read-side stream
    output logic [`DCFIFO_DATA_W-1:0] out_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      out_startofpacket,
    output logic                      out_endofpacket,

    // Input status port
    input  logic                      in_csr_address,
    input  logic                      in_csr_read,
    input  logic                      in_csr_write,
    input  logic [`DCFIFO_CSR_W-1:0]  in_csr_writedata,
    output logic [`DCFIFO_CSR_W-1:0]  in_csr_readdata,

    // Output status port
    input  logic                      out_csr_address,
    input  logic                      out_csr_read,
    input  logic                      out_csr_write,
    input  logic [`DCFIFO_CSR_W-1:0]  out_csr_writedata,
    output logic [`DCFIFO_CSR_W-1:0]  out_csr_readdata,

    output logic                      almost_full,
    output logic                      almost_empty
);

    logic                      wr_en;
    logic [`DCFIFO_ADDR_W-1:0] wr_addr;
    logic [`DCFIFO_ADDR_W-1:0] rd_addr;
    logic [`DCFIFO_DATA_W+1:0] mem_data;
    ptr_t                      wr_ptr_gray;
    ptr_t                      wr_ptr_gray_sync;
    ptr_t                      rd_ptr_gray;
    ptr_t                      rd_ptr_gray_sync;
    ptr_t                      in_fill_level;
    ptr_t                      out_fill_level;

    // --------------------
    // Storage
    // --------------------

    payload_ram ram_i (
        .wr_clk  (in_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data ({in_startofpacket, in_endofpacket, in_data}),
        .rd_clk  (out_clk),
        .rd_addr (rd_addr),
        .rd_data (mem_data)
    );

    // --------------------
    // Write domain
    // --------------------

    fifo_write_side write_side_i (
        .in_clk           (in_clk),
        .in_reset_n       (in_reset_n),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .rd_ptr_gray_sync (rd_ptr_gray_sync),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_ptr_gray      (wr_ptr_gray),
        .in_fill_level    (in_fill_level)
    );

    // Read pointer into the write domain
    gray_sync #(
        .WIDTH  ($bits(ptr_t)),
        .STAGES (`DCFIFO_SYNC_STAGES)
    ) read_sync_i (
        .in_clk     (in_clk),
        .in_reset_n (in_reset_n),
        .gray_in    (rd_ptr_gray),
        .gray_out   (rd_ptr_gray_sync)
    );

    // Input level and almost full
    level_status #(
        .ALMOST_ABOVE (1'b1)
    ) in_status_i (
        .in_clk        (in_clk),
        .in_reset_n    (in_reset_n),
        .fill_level    (in_fill_level),
        .csr_address   (in_csr_address),
        .csr_read      (in_csr_read),
        .csr_write     (in_csr_write),
        .csr_writedata (in_csr_writedata),
        .csr_readdata  (in_csr_readdata),
        .almost        (almost_full)
    );

    // --------------------
    // Read domain
    // --------------------

    fifo_read_side read_side_i (
        .out_clk           (out_clk),
        .out_reset_n       (out_reset_n),
        .wr_ptr_gray_sync  (wr_ptr_gray_sync),
        .rd_addr           (rd_addr),
        .rd_ptr_gray       (rd_ptr_gray),
        .mem_data          (mem_data),
        .out_ready         (out_ready),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .out_startofpacket (out_startofpacket),
        .out_endofpacket   (out_endofpacket),
        .out_fill_level    (out_fill_level)
    );

    // Write pointer into the read domain
    gray_sync #(
        .WIDTH  ($bits(ptr_t)),
        .STAGES (`DCFIFO_SYNC_STAGES)
    ) write_sync_i (
        .in_clk     (out_clk),
        .in_reset_n (out_reset_n),
        .gray_in    (wr_ptr_gray),
        .gray_out   (wr_ptr_gray_sync)
    );

    // Output level and almost empty
    level_status #(
        .ALMOST_ABOVE (1'b0)
    ) out_status_i (
        .in_clk        (out_clk),
        .in_reset_n    (out_reset_n),
        .fill_level    (out_fill_level),
        .csr_address   (out_csr_address),
        .csr_read      (out_csr_read),
        .csr_write     (out_csr_write),
        .csr_writedata (out_csr_writedata),
        .csr_readdata  (out_csr_readdata),
        .almost        (almost_empty)
    );

endmodule

`default_nettype wire

// ==== tb/dcfifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_defines.svh"

module dcfifo_tb;

    localparam int IN_HALF = 4;
    localparam int OUT_HALF = 7;
    localparam int SEED = 32'h571c_38b3;
    localparam int DATA_W = `DCFIFO_DATA_W;
    localparam int MAX_STEPS = 40;
    // Cycles without progress before a wait gives up
    localparam int IDLE_LIMIT = 400;
    // in_ready low this long counts as full
    localparam int FULL_HOLD = 40;
    // Gray register, sync chain, flags and status registers
    localparam int SETTLE_CYCLES = 4 * `DCFIFO_SYNC_STAGES + 8;

    // Step operations
    localparam int OP_RESET = 0;
    localparam int OP_STREAM = 1;
    localparam int OP_FILL = 2;
    localparam int OP_PUSH = 3;
    localparam int OP_DRAIN = 4;
    localparam int OP_READ = 5;
    localparam int OP_WRITE = 6;
    localparam int OP_ALMOST = 7;

    logic in_clk;
    logic in_reset_n;
    logic out_clk;
    logic out_reset_n;
    logic [DATA_W-1:0] in_data;
    logic in_valid;
    logic in_ready;
    logic in_startofpacket;
    logic in_endofpacket;
    logic [DATA_W-1:0] out_data;
    logic out_valid;
    logic out_ready;
    logic out_startofpacket;
    logic out_endofpacket;
    logic in_csr_address;
    logic in_csr_read;
    logic in_csr_write;
    logic [`DCFIFO_CSR_W-1:0] in_csr_writedata;
    logic [`DCFIFO_CSR_W-1:0] in_csr_readdata;
    logic out_csr_address;
    logic out_csr_read;
    logic out_csr_write;
    logic [`DCFIFO_CSR_W-1:0] out_csr_writedata;
    logic [`DCFIFO_CSR_W-1:0] out_csr_readdata;
    logic almost_full;
    logic almost_empty;

    // Scoreboard of accepted beats, {sop, eop, data}
    logic [DATA_W+1:0] sb_q [$];
    int step_op [MAX_STEPS];
    int step_side [MAX_STEPS];
    logic [31:0] step_arg [MAX_STEPS];
    logic [31:0] step_exp [MAX_STEPS];
    string op_names [8] = '{"reset", "stream", "fill", "push", "drain", "read", "write", "almost"};
    int n_steps;
    int n_errors;
    int pkt_left;
    bit timed_out;

    dcfifo_top dut_i (.*);

    initial begin
        in_clk = 1'b0;
        forever #(IN_HALF) in_clk = ~in_clk;
    end

    initial begin
        out_clk = 1'b0;
        forever #(OUT_HALF) out_clk = ~out_clk;
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic add_step(input int op, input int side, input logic [31:0] arg,
                            input logic [31:0] exp);
        step_op[n_steps] = op;
        step_side[n_steps] = side;
        step_arg[n_steps] = arg;
        step_exp[n_steps] = exp;
        n_steps++;
    endtask

    task automatic report_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        n_errors++;
        $display("[FAIL] %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    endtask

    task automatic note_timeout(input string what);
        n_errors++;
        timed_out = 1'b1;
        $display("Timeout while waiting for %s", what);
    endtask

    // Random packets of 1 to 8 beats
    function automatic logic [DATA_W+1:0] next_beat();
        logic sop;
        logic eop;
        sop = (pkt_left == 0);
        if (sop) begin
            pkt_left = int'($urandom_range(1, 8));
        end
        eop = (pkt_left == 1);
        pkt_left--;
        return {sop, eop, DATA_W'($urandom)};
    endfunction

    // Count mode stops after n beats, full mode once in_ready stays low
    task automatic push_beats(input int n, input bit gaps, input bit until_full,
                              output int accepted);
        logic [DATA_W+1:0] beat;
        bit pending;
        int idle;
        int low_run;
        accepted = 0;
        pending = 1'b0;
        idle = 0;
        low_run = 0;
        beat = '0;
        while (!timed_out && (until_full ? low_run < FULL_HOLD : accepted < n)) begin
            @(posedge in_clk);
            #1;
            if (!pending && (!gaps || $urandom_range(0, 3) != 0)) begin
                beat = next_beat();
                pending = 1'b1;
            end
            in_valid = pending;
            {in_startofpacket, in_endofpacket, in_data} = beat;
            // Registered in_ready holds until the edge that takes the beat
            if (pending && in_ready) begin
                sb_q.push_back(beat);
                accepted++;
                pending = 1'b0;
                idle = 0;
                low_run = 0;
            end else begin
                idle++;
                low_run = in_ready ? 0 : low_run + 1;
            end
            if (idle > IDLE_LIMIT || (until_full && accepted > 4 * `DCFIFO_DEPTH)) begin
                note_timeout("the input side to accept beats or fill up");
            end
        end
        // Last counted beat still needs its edge
        if (!until_full) begin
            @(posedge in_clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic drain_beats(input int n, input bit random_ready);
        logic [DATA_W+1:0] got;
        logic [DATA_W+1:0] exp;
        int taken;
        int idle;
        taken = 0;
        idle = 0;
        while (!timed_out && taken < n) begin
            @(posedge out_clk);
            #1;
            out_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
            got = {out_startofpacket, out_endofpacket, out_data};
            if (out_valid && out_ready) begin
                taken++;
                idle = 0;
                if (sb_q.size() == 0) begin
                    n_errors++;
                    $display("[FAIL] %0d ns: beat 0x%0h with none expected", $time, got);
                end else begin
                    exp = sb_q.pop_front();
                    if (got !== exp) begin
                        report_value("output beat {sop,eop,data}", 32'(got), 32'(exp));
                    end
                end
            end else begin
                idle++;
                if (idle > IDLE_LIMIT) begin
                    note_timeout("the next output beat");
                end
            end
        end
        @(posedge out_clk);
        #1;
        out_ready = 1'b0;
    endtask

    // Side 0 is the input status port, side 1 the output one
    task automatic csr_access(input int side, input bit write, input logic addr,
                              input logic [`DCFIFO_CSR_W-1:0] wdata,
                              output logic [`DCFIFO_CSR_W-1:0] rdata);
        if (side == 0) begin
            @(posedge in_clk);
            #1;
            in_csr_address = addr;
            in_csr_write = write;
            in_csr_read = !write;
            in_csr_writedata = wdata;
            @(posedge in_clk);
            #1;
            in_csr_write = 1'b0;
            in_csr_read = 1'b0;
            rdata = in_csr_readdata;
        end else begin
            @(posedge out_clk);
            #1;
            out_csr_address = addr;
            out_csr_write = write;
            out_csr_read = !write;
            out_csr_writedata = wdata;
            @(posedge out_clk);
            #1;
            out_csr_write = 1'b0;
            out_csr_read = 1'b0;
            rdata = out_csr_readdata;
        end
    endtask

    // Long enough for both crossings and the status registers
    task automatic settle();
        repeat (SETTLE_CYCLES) @(posedge out_clk);
        #1;
    endtask

    // --------------------
    // Stimulus table
    // --------------------

    task automatic load_table();
        add_step(OP_RESET, 0, 0, 0);
        add_step(OP_READ, 0, 1, 0);
        add_step(OP_READ, 1, 1, 0);
        add_step(OP_STREAM, 0, 120, 0);
        // 16 memory words plus the output stage
        add_step(OP_FILL, 0, 0, `DCFIFO_DEPTH + 1);
        add_step(OP_DRAIN, 0, `DCFIFO_DEPTH + 1, 0);
        // Zero thresholds and empty FIFO, both bits set
        add_step(OP_ALMOST, 0, 0, 32'h3);
        // Input level K-1, output level K
        add_step(OP_PUSH, 0, 5, 0);
        add_step(OP_READ, 0, 0, 4);
        add_step(OP_READ, 1, 0, 5);
        add_step(OP_DRAIN, 0, 5, 0);
        add_step(OP_PUSH, 0, 16, 0);
        add_step(OP_READ, 0, 0, 15);
        add_step(OP_READ, 1, 0, 16);
        add_step(OP_DRAIN, 0, 16, 0);
        add_step(OP_PUSH, 0, 1, 0);
        add_step(OP_READ, 0, 0, 0);
        add_step(OP_READ, 1, 0, 1);
        add_step(OP_DRAIN, 0, 1, 0);
        // Upper bits written, only the 24-bit field reads back
        add_step(OP_WRITE, 0, 1, 32'hA500_0006);
        add_step(OP_READ, 0, 1, 32'h0000_0006);
        add_step(OP_WRITE, 1, 1, 32'h5A00_0003);
        add_step(OP_READ, 1, 1, 32'h0000_0003);
        // Bit 1 almost_full, bit 0 almost_empty
        add_step(OP_ALMOST, 0, 0, 32'h1);
        add_step(OP_PUSH, 0, 3, 0);
        add_step(OP_ALMOST, 0, 0, 32'h1);
        add_step(OP_PUSH, 0, 4, 0);
        add_step(OP_READ, 0, 0, 6);
        add_step(OP_READ, 1, 0, 7);
        add_step(OP_ALMOST, 0, 0, 32'h2);
        add_step(OP_DRAIN, 0, 7, 0);
        add_step(OP_ALMOST, 0, 0, 32'h1);
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        logic [`DCFIFO_CSR_W-1:0] rdata;
        int accepted;
        int errs_before;
        int steps_run;
        int steps_failed;
        void'($urandom(SEED));
        in_reset_n = 1'b0;
        out_reset_n = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        in_startofpacket = 1'b0;
        in_endofpacket = 1'b0;
        out_ready = 1'b0;
        in_csr_address = 1'b0;
        in_csr_read = 1'b0;
        in_csr_write = 1'b0;
        in_csr_writedata = '0;
        out_csr_address = 1'b0;
        out_csr_read = 1'b0;
        out_csr_write = 1'b0;
        out_csr_writedata = '0;
        n_steps = 0;
        n_errors = 0;
        pkt_left = 0;
        timed_out = 1'b0;
        steps_run = 0;
        steps_failed = 0;
        load_table();
        // Each reset held for two cycles of its own clock
        fork
            begin
                repeat (2) @(posedge in_clk);
                #1;
                in_reset_n = 1'b1;
            end
            begin
                repeat (2) @(posedge out_clk);
                #1;
                out_reset_n = 1'b1;
            end
        join
        for (int i = 0; i < n_steps && !timed_out; i++) begin
            errs_before = n_errors;
            case (step_op[i])
                OP_RESET: begin
                    if (in_ready !== 1'b1) begin
                        report_value("in_ready after reset", 32'(in_ready), 1);
                    end
                    if (out_valid !== 1'b0) begin
                        report_value("out_valid after reset", 32'(out_valid), 0);
                    end
                    if (in_csr_readdata !== '0) begin
                        report_value("input readdata", in_csr_readdata, 0);
                    end
                    if (out_csr_readdata !== '0) begin
                        report_value("output readdata", out_csr_readdata, 0);
                    end
                end
                OP_STREAM: begin
                    fork
                        push_beats(step_arg[i], 1'b1, 1'b0, accepted);
                        drain_beats(step_arg[i], 1'b1);
                    join
                    settle();
                end
                OP_FILL: begin
                    push_beats(0, 1'b0, 1'b1, accepted);
                    if (accepted != int'(step_exp[i])) begin
                        report_value("beats accepted until full", accepted, step_exp[i]);
                    end
                    settle();
                end
                OP_PUSH: begin
                    push_beats(step_arg[i], 1'b0, 1'b0, accepted);
                    settle();
                end
                OP_DRAIN: begin
                    drain_beats(step_arg[i], 1'b0);
                    if (sb_q.size() != 0) report_value("beats left over", sb_q.size(), 0);
                    settle();
                end
                OP_READ: begin
                    csr_access(step_side[i], 1'b0, step_arg[i][0], '0, rdata);
                    if (rdata !== step_exp[i]) report_value("status word", rdata, step_exp[i]);
                    if (rdata[31:24] !== 8'h00) report_value("upper status bits", rdata, 0);
                end
                OP_WRITE: begin
                    csr_access(step_side[i], 1'b1, step_arg[i][0], step_exp[i], rdata);
                end
                default: begin
                    if ({almost_full, almost_empty} !== step_exp[i][1:0]) begin
                        report_value("{almost_full,almost_empty}",
                                     32'({almost_full, almost_empty}), step_exp[i]);
                    end
                end
            endcase
            steps_run++;
            if (n_errors != errs_before) steps_failed++;
            $display("step %0d %s: %s", i, op_names[step_op[i]],
                     (n_errors == errs_before) ? "ok" : "mismatch");
        end
        $display("steps run %0d, steps failed %0d, errors %0d", steps_run, steps_failed, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/dcfifo_pkg.sv
src/gray_sync.sv
src/payload_ram.sv
src/fifo_write_side.sv
src/fifo_read_side.sv
src/level_status.sv
src/dcfifo_top.sv
tb/dcfifo_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcfifo_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
